//--- include/polar_config.svh
/*
  frame size, leaf size and LLR width of the 16-bit polar decoder
*/

`ifndef POLAR_CONFIG_SVH
`define POLAR_CONFIG_SVH

// frame length in bits
`define POLAR_N      16

// leaf decoder length
`define POLAR_LEAF   8

// signed two's complement LLR width
`define POLAR_LLR_W  4

`endif

//--- design/polar_pkg.sv
/*
  polar decoder types and leaf type enum
  min-sum F/G, hard decision, 4-bit encode/decode and leaf classifier
*/

`include "polar_config.svh"

package polar_pkg;

  // saturation bounds of one LLR
  localparam int LLR_MAX = (1 << (`POLAR_LLR_W - 1)) - 1;
  localparam int LLR_MIN = -(1 << (`POLAR_LLR_W - 1));

  typedef logic signed [`POLAR_LLR_W-1:0] llr_t;
  typedef llr_t [`POLAR_LEAF-1:0]          alpha_w_t;
  typedef llr_t [`POLAR_LEAF/2-1:0]        alpha_hw_t;
  typedef logic [`POLAR_LEAF-1:0]          beta_w_t;

  // names read msb half first, so rate0_4_x_4 has the upper 4 bits frozen
  typedef enum logic [2:0] {
    leaf_rate0_8,
    leaf_rate1_8,
    leaf_rate0_4_x_4,
    leaf_x_4_rate0_4,
    leaf_x_8
  } leaf_type_t;

  //--------------------------------------------------------------------------
  // min-sum arithmetic
  //--------------------------------------------------------------------------

  // clip one guard bit back into the LLR range
  function automatic llr_t sat_llr(logic signed [`POLAR_LLR_W:0] v);
    if (v > LLR_MAX) return llr_t'(LLR_MAX);
    if (v < LLR_MIN) return llr_t'(LLR_MIN);
    return v[`POLAR_LLR_W-1:0];
  endfunction

  // sign product times min magnitude
  function automatic llr_t f_op(llr_t a, llr_t b);
    logic signed [`POLAR_LLR_W:0] ea;
    logic signed [`POLAR_LLR_W:0] eb;
    logic signed [`POLAR_LLR_W:0] m;
    ea = a;
    eb = b;
    // magnitudes, -min fits thanks to the guard bit
    ea = (ea < 0) ? -ea : ea;
    eb = (eb < 0) ? -eb : eb;
    m  = (ea < eb) ? ea : eb;
    return sat_llr((a[`POLAR_LLR_W-1] ^ b[`POLAR_LLR_W-1]) ? -m : m);
  endfunction

  // b + a for partial sum 0, b - a for partial sum 1
  function automatic llr_t g_op(llr_t a, llr_t b, logic s);
    logic signed [`POLAR_LLR_W:0] ea;
    logic signed [`POLAR_LLR_W:0] eb;
    ea = a;
    eb = b;
    return sat_llr(s ? (eb - ea) : (eb + ea));
  endfunction

  // negative LLR decides 1, zero decides 0
  function automatic logic hard_bit(llr_t a);
    return a[`POLAR_LLR_W-1];
  endfunction

  //--------------------------------------------------------------------------
  // 4-bit polar transform and SC decode
  //--------------------------------------------------------------------------

  function automatic logic [3:0] enc4(logic [3:0] u);
    return {u[3], u[2] ^ u[3], u[1] ^ u[3], ^u};
  endfunction

  // full SC over 4 LLRs, returns the re-encoded beta
  function automatic logic [3:0] dec4(alpha_hw_t a, logic [3:0] frz);
    llr_t       l0;
    llr_t       l1;
    llr_t       r0;
    llr_t       r1;
    logic [3:0] u;
    // left 2-node
    l0   = f_op(a[0], a[2]);
    l1   = f_op(a[1], a[3]);
    u[0] = frz[0] ? 1'b0 : hard_bit(f_op(l0, l1));
    u[1] = frz[1] ? 1'b0 : hard_bit(g_op(l0, l1, u[0]));
    // right 2-node, partial sums are the left beta
    r0   = g_op(a[0], a[2], u[0] ^ u[1]);
    r1   = g_op(a[1], a[3], u[1]);
    u[2] = frz[2] ? 1'b0 : hard_bit(f_op(r0, r1));
    u[3] = frz[3] ? 1'b0 : hard_bit(g_op(r0, r1, u[2]));
    return enc4(u);
  endfunction

  // frozen mask to leaf fast path, 1 means frozen
  function automatic leaf_type_t classify8(beta_w_t frz);
    if (&frz)        return leaf_rate0_8;
    if (frz == '0)   return leaf_rate1_8;
    if (&frz[7:4])   return leaf_rate0_4_x_4;
    if (&frz[3:0])   return leaf_x_4_rate0_4;
    return leaf_x_8;
  endfunction

endpackage

//--- design/polar_frame_in.sv
/*
  input stage of the 16-bit polar decoder
  registers LLRs and frozen mask, classifies both mask halves
*/

`timescale 1ns/1ps
`include "polar_config.svh"

module polar_frame_in import polar_pkg::*; (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                iclkena,
  // incoming frame
  input  logic                ialpha_val,
  input  alpha_w_t [1:0]      ialpha,
  input  logic [`POLAR_N-1:0] ifrzb,
  // registered frame
  output logic                frm_val,
  output alpha_w_t [1:0]      frm_alpha,
  output logic [`POLAR_N-1:0] frm_frzb,
  output leaf_type_t          frm_type_lo,
  output leaf_type_t          frm_type_hi
);

  //--------------------------------------------------------------------------
  // strobe delay
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      frm_val <= 1'b0;
    end else if (iclkena) begin
      frm_val <= ialpha_val;
    end
  end

  //--------------------------------------------------------------------------
  // frame capture
  //--------------------------------------------------------------------------

  // loaded only on the strobe, held until the next frame
  always_ff @(posedge iclk) begin
    if (iclkena && ialpha_val) begin
      frm_alpha   <= ialpha;
      frm_frzb    <= ifrzb;
      // leaf types ready before the root node needs them
      frm_type_lo <= classify8(ifrzb[`POLAR_LEAF-1:0]);
      frm_type_hi <= classify8(ifrzb[`POLAR_N-1 -: `POLAR_LEAF]);
    end
  end

endmodule

//--- design/polar_leaf_dec8.sv
/*
  unrolled 8-LLR polar leaf decoder
  rate-0 and rate-1 in zero cycles, half-rate0 leaves in 2, full leaf in 4
*/

`timescale 1ns/1ps
`include "polar_config.svh"

module polar_leaf_dec8 import polar_pkg::*; (
  input  logic       iclk,
  input  logic       ireset,
  input  logic       iclkena,
  // leaf LLRs
  input  logic       ialpha_val,
  input  alpha_w_t   ialpha,
  // frozen mask and its precomputed type
  input  beta_w_t    ifrzb,
  input  leaf_type_t ifrzb_type,
  // leaf beta
  output logic       obeta_val,
  output beta_w_t    obeta
);

  localparam int HW = `POLAR_LEAF / 2;

  logic [2:0]  val;
  logic [3:0]  bval;

  alpha_hw_t   tmp_fg4;
  alpha_hw_t   tmp_g4_ones;
  alpha_hw_t   tmp_g4_zeros;

  beta_w_t     decodeb;
  beta_w_t     frozenb;
  beta_w_t     hard8;

  //--------------------------------------------------------------------------
  // step sequencer
  //   val[0] decode low half, val[1] select G4, val[2] decode high half
  //   bval[3] marks the result
  //   rate0_4_x_4 skips the high decode
  //   x_4_rate0_4 starts at val[2]
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val  <= '0;
      bval <= '0;
    end else if (iclkena) begin
      val  <= val << 1;
      bval <= bval << 1;
      if (ialpha_val) begin
        case (ifrzb_type)
          leaf_rate0_8,
          leaf_rate1_8     : begin
            val  <= 3'b000;
            bval <= 4'b0000;
          end
          leaf_rate0_4_x_4 : begin
            val  <= 3'b001;
            bval <= 4'b0100;
          end
          leaf_x_4_rate0_4 : begin
            val  <= 3'b100;
            bval <= 4'b0100;
          end
          default          : begin
            val  <= 3'b001;
            bval <= 4'b0001;
          end
        endcase
      end
    end
  end

  //--------------------------------------------------------------------------
  // fast paths and result
  //--------------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < `POLAR_LEAF; i++) begin
      hard8[i] = hard_bit(ialpha[i]);
    end
  end

  // rate-0 and rate-1 leaves answer combinationally
  assign obeta_val = (ialpha_val && (ifrzb_type == leaf_rate0_8 ||
                                     ifrzb_type == leaf_rate1_8)) || bval[3];

  // pipelined result re-encodes the two 4-bit betas
  assign obeta = ialpha_val ? ((ifrzb_type == leaf_rate1_8) ? hard8 : '0)
                            : {decodeb[HW +: HW], decodeb[0 +: HW] ^ decodeb[HW +: HW]};

  //--------------------------------------------------------------------------
  // pipelined data path for the mixed and full leaves
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (ialpha_val) begin
        frozenb <= ifrzb;
        decodeb <= '0;
        // both G4 variants ahead of the low-half decision
        for (int i = 0; i < HW; i++) begin
          tmp_fg4[i]      <= f_op(ialpha[i], ialpha[i + HW]);
          tmp_g4_ones[i]  <= g_op(ialpha[i], ialpha[i + HW], 1'b1);
          tmp_g4_zeros[i] <= g_op(ialpha[i], ialpha[i + HW], 1'b0);
          // a frozen low half goes straight to G with zero partial sums
          if (ifrzb_type == leaf_x_4_rate0_4) begin
            tmp_fg4[i] <= g_op(ialpha[i], ialpha[i + HW], 1'b0);
          end
        end
      end else if (val[0]) begin
        decodeb[0 +: HW] <= dec4(tmp_fg4, frozenb[0 +: HW]);
      end else if (val[1]) begin
        for (int i = 0; i < HW; i++) begin
          tmp_fg4[i] <= decodeb[i] ? tmp_g4_ones[i] : tmp_g4_zeros[i];
        end
      end else if (val[2]) begin
        decodeb[HW +: HW] <= dec4(tmp_fg4, frozenb[HW +: HW]);
      end
    end
  end

endmodule

//--- design/polar_root_node16.sv
/*
  root node of the 16-bit SC decoder
  F/G sequencing over two 8-bit leaves and final beta combine
*/

`timescale 1ns/1ps
`include "polar_config.svh"

module polar_root_node16 import polar_pkg::*; (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                iclkena,
  // frame from the input stage
  input  logic                frm_val,
  input  alpha_w_t [1:0]      frm_alpha,
  input  logic [`POLAR_N-1:0] frm_frzb,
  input  leaf_type_t          frm_type_lo,
  input  leaf_type_t          frm_type_hi,
  // leaf decoder return
  input  logic                leaf_beta_val,
  input  beta_w_t             leaf_beta,
  // leaf decoder request
  output logic                leaf_alpha_val,
  output alpha_w_t            leaf_alpha,
  output beta_w_t             leaf_frzb,
  output leaf_type_t          leaf_frzb_type,
  // decoded codeword estimate
  output logic                obeta_val,
  output logic [`POLAR_N-1:0] obeta,
  output logic                obusy
);

  typedef enum logic [2:0] {
    st_idle,
    st_left,
    st_wait_left,
    st_right,
    st_wait_right,
    st_done
  } state_t;

  state_t                state;

  logic                  in_left;
  logic                  in_right;

  alpha_w_t              f_vec;
  alpha_w_t              g_vec;

  alpha_w_t [1:0]        alpha_r;
  logic [`POLAR_N-1:0]   frzb_r;
  leaf_type_t            type_lo_r;
  leaf_type_t            type_hi_r;
  alpha_w_t              fg_r;
  beta_w_t               beta_l_r;
  logic [`POLAR_N-1:0]   obeta_r;

  //--------------------------------------------------------------------------
  // node arithmetic
  //--------------------------------------------------------------------------

  // F pairs llr i with llr i+8 of the new frame
  // G uses the stored frame and the left beta as partial sums
  always_comb begin
    for (int i = 0; i < `POLAR_LEAF; i++) begin
      f_vec[i] = f_op(frm_alpha[0][i], frm_alpha[1][i]);
      g_vec[i] = g_op(alpha_r[0][i], alpha_r[1][i], leaf_beta[i]);
    end
  end

  //--------------------------------------------------------------------------
  // phase FSM
  //--------------------------------------------------------------------------

  // rate-0/rate-1 leaves answer in the issue cycle, so both
  // the issue and the wait phase accept a beta
  assign in_left  = (state == st_left)  || (state == st_wait_left);
  assign in_right = (state == st_right) || (state == st_wait_right);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= st_idle;
    end else if (iclkena) begin
      case (state)
        st_idle       : if (frm_val) state <= st_left;
        st_left,
        st_wait_left  : state <= leaf_beta_val ? st_right : st_wait_left;
        st_right,
        st_wait_right : state <= leaf_beta_val ? st_done : st_wait_right;
        st_done       : state <= st_idle;
        default       : state <= st_idle;
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // data path registers
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      // frames arriving while busy are dropped here
      if (state == st_idle && frm_val) begin
        alpha_r   <= frm_alpha;
        frzb_r    <= frm_frzb;
        type_lo_r <= frm_type_lo;
        type_hi_r <= frm_type_hi;
        fg_r      <= f_vec;
      end
      // left beta done, prepare the right child LLRs
      if (in_left && leaf_beta_val) begin
        beta_l_r <= leaf_beta;
        fg_r     <= g_vec;
      end
      // upper half is the right beta, lower half left xor right
      if (in_right && leaf_beta_val) begin
        obeta_r <= {leaf_beta, beta_l_r ^ leaf_beta};
      end
    end
  end

  //--------------------------------------------------------------------------
  // outputs
  //--------------------------------------------------------------------------

  assign leaf_alpha_val = (state == st_left) || (state == st_right);
  assign leaf_alpha     = fg_r;
  assign leaf_frzb      = in_right ? frzb_r[`POLAR_N-1 -: `POLAR_LEAF]
                                   : frzb_r[`POLAR_LEAF-1:0];
  assign leaf_frzb_type = in_right ? type_hi_r : type_lo_r;

  assign obeta_val      = (state == st_done);
  assign obeta          = obeta_r;

  // frm_val covers the cycle before the FSM leaves idle
  assign obusy          = frm_val || (state != st_idle && state != st_done);

endmodule

//--- design/polar_dec16_top.sv
/*
  16-bit SC polar decoder top
  frame stage, root node and 8-LLR leaf decoder
*/

`timescale 1ns/1ps
`include "polar_config.svh"

module polar_dec16_top import polar_pkg::*; (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                iclkena,
  // channel frame
  input  logic                ialpha_val,
  input  alpha_w_t [1:0]      ialpha,
  input  logic [`POLAR_N-1:0] ifrzb,
  // codeword estimate
  output logic                obeta_val,
  output logic [`POLAR_N-1:0] obeta,
  output logic                obusy
);

  logic                frm_val;
  alpha_w_t [1:0]      frm_alpha;
  logic [`POLAR_N-1:0] frm_frzb;
  leaf_type_t          frm_type_lo;
  leaf_type_t          frm_type_hi;

  logic                leaf_alpha_val;
  alpha_w_t            leaf_alpha;
  beta_w_t             leaf_frzb;
  leaf_type_t          leaf_frzb_type;
  logic                leaf_beta_val;
  beta_w_t             leaf_beta;

  //--------------------------------------------------------------------------
  // stage 1 capture and classify
  //--------------------------------------------------------------------------

  polar_frame_in polar_frame_in_i (
    .iclk        (iclk),
    .ireset      (ireset),
    .iclkena     (iclkena),
    .ialpha_val  (ialpha_val),
    .ialpha      (ialpha),
    .ifrzb       (ifrzb),
    .frm_val     (frm_val),
    .frm_alpha   (frm_alpha),
    .frm_frzb    (frm_frzb),
    .frm_type_lo (frm_type_lo),
    .frm_type_hi (frm_type_hi)
  );

  //--------------------------------------------------------------------------
  // stage 2 root node
  //--------------------------------------------------------------------------

  polar_root_node16 polar_root_node16_i (
    .iclk           (iclk),
    .ireset         (ireset),
    .iclkena        (iclkena),
    .frm_val        (frm_val),
    .frm_alpha      (frm_alpha),
    .frm_frzb       (frm_frzb),
    .frm_type_lo    (frm_type_lo),
    .frm_type_hi    (frm_type_hi),
    .leaf_beta_val  (leaf_beta_val),
    .leaf_beta      (leaf_beta),
    .leaf_alpha_val (leaf_alpha_val),
    .leaf_alpha     (leaf_alpha),
    .leaf_frzb      (leaf_frzb),
    .leaf_frzb_type (leaf_frzb_type),
    .obeta_val      (obeta_val),
    .obeta          (obeta),
    .obusy          (obusy)
  );

  //--------------------------------------------------------------------------
  // stage 3 leaf decoder, shared by both children
  //--------------------------------------------------------------------------

  polar_leaf_dec8 polar_leaf_dec8_i (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .ialpha_val (leaf_alpha_val),
    .ialpha     (leaf_alpha),
    .ifrzb      (leaf_frzb),
    .ifrzb_type (leaf_frzb_type),
    .obeta_val  (leaf_beta_val),
    .obeta      (leaf_beta)
  );

endmodule

//--- sim/tb_polar_dec16.sv
/*
  testbench for the 16-bit SC polar decoder
  random frames and masks, reference SC model, clock enable stalls, watchdog
*/

`timescale 1ns/1ps
`include "polar_config.svh"

module tb_polar_dec16;

  localparam int CLK_PERIOD   = 20;
  localparam int NUM_FRAMES   = 300;
  localparam int STALL_FRAMES = 100;
  localparam int FRAME_CYC    = 12;
  // stalled frames get four times the budget
  localparam int TIMEOUT_NS   = (NUM_FRAMES * FRAME_CYC + STALL_FRAMES * FRAME_CYC * 4 + 200)
                                * CLK_PERIOD;
  localparam int LMAX         = (1 << (`POLAR_LLR_W - 1)) - 1;
  localparam int LMIN         = -(1 << (`POLAR_LLR_W - 1));

  logic                              iclk;
  logic                              ireset;
  logic                              iclkena;
  logic                              ialpha_val;
  logic [`POLAR_N*`POLAR_LLR_W-1:0]  ialpha;
  logic [`POLAR_N-1:0]               ifrzb;
  logic                              obeta_val;
  logic [`POLAR_N-1:0]               obeta;
  logic                              obusy;

  // expected betas in frame order
  logic [`POLAR_N-1:0]               exp_q[$];
  int                                errors;
  int                                frames_done;
  bit                                in_flight;
  bit                                stall_on;

  // outputs taken at the falling edge
  logic                              s_val;
  logic                              s_busy;
  logic [`POLAR_N-1:0]               s_beta;

  polar_dec16_top polar_dec16_top_i (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .ialpha_val (ialpha_val),
    .ialpha     (ialpha),
    .ifrzb      (ifrzb),
    .obeta_val  (obeta_val),
    .obeta      (obeta),
    .obusy      (obusy)
  );

  always #(CLK_PERIOD / 2) iclk = ~iclk;

  //--------------------------------------------------------------------------
  // reference SC model with min-sum and saturation
  //--------------------------------------------------------------------------

  function automatic int saturate(int v);
    if (v > LMAX) return LMAX;
    if (v < LMIN) return LMIN;
    return v;
  endfunction

  function automatic int check_node(int a, int b);
    int ma;
    int mb;
    int m;
    ma = (a < 0) ? -a : a;
    mb = (b < 0) ? -b : b;
    m  = (ma < mb) ? ma : mb;
    return saturate(((a < 0) != (b < 0)) ? -m : m);
  endfunction

  // b + a or b - a by the partial sum
  function automatic int bit_node(int a, int b, logic s);
    return saturate(s ? b - a : b + a);
  endfunction

  function automatic logic hard_decision(int a);
    return (a < 0);
  endfunction

  // two-bit node where frozen bits decide 0
  function automatic logic [1:0] two_bit_sc(int a0, int a1, logic [1:0] frz);
    logic u0;
    logic u1;
    u0 = frz[0] ? 1'b0 : hard_decision(check_node(a0, a1));
    u1 = frz[1] ? 1'b0 : hard_decision(bit_node(a0, a1, u0));
    return {u1, u0 ^ u1};
  endfunction

  function automatic logic [3:0] four_bit_sc(int a[4], logic [3:0] frz);
    int         l[2];
    int         r[2];
    logic [1:0] bl;
    logic [1:0] br;
    for (int i = 0; i < 2; i++) l[i] = check_node(a[i], a[i + 2]);
    bl = two_bit_sc(l[0], l[1], frz[1:0]);
    for (int i = 0; i < 2; i++) r[i] = bit_node(a[i], a[i + 2], bl[i]);
    br = two_bit_sc(r[0], r[1], frz[3:2]);
    return {br, bl ^ br};
  endfunction

  // eight-bit node with the leaf shortcuts so that zero ties decide like the leaf
  function automatic logic [7:0] eight_bit_sc(int a[8], logic [7:0] frz);
    int         l[4];
    int         r[4];
    logic [3:0] bl;
    logic [3:0] br;
    logic [7:0] hard;
    if (frz == 8'hff) return 8'h00;
    if (frz == 8'h00) begin
      for (int i = 0; i < 8; i++) hard[i] = hard_decision(a[i]);
      return hard;
    end
    for (int i = 0; i < 4; i++) l[i] = check_node(a[i], a[i + 4]);
    bl = four_bit_sc(l, frz[3:0]);
    for (int i = 0; i < 4; i++) r[i] = bit_node(a[i], a[i + 4], bl[i]);
    br = four_bit_sc(r, frz[7:4]);
    return {br, bl ^ br};
  endfunction

  function automatic logic [15:0] frame_sc(int a[16], logic [15:0] frz);
    int         l[8];
    int         r[8];
    logic [7:0] bl;
    logic [7:0] br;
    for (int i = 0; i < 8; i++) l[i] = check_node(a[i], a[i + 8]);
    bl = eight_bit_sc(l, frz[7:0]);
    for (int i = 0; i < 8; i++) r[i] = bit_node(a[i], a[i + 8], bl[i]);
    br = eight_bit_sc(r, frz[15:8]);
    return {br, bl ^ br};
  endfunction

  //--------------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------------

  function automatic logic [`POLAR_LLR_W-1:0] pick_llr();
    logic [`POLAR_LLR_W-1:0] v;
    v = `POLAR_LLR_W'($urandom);
    // range ends drive F and G into saturation
    if ($urandom_range(0, 3) == 0) begin
      v = {1'b1, {(`POLAR_LLR_W-1){1'b0}}};
      if ($urandom_range(0, 1) == 1) v = ~v;
    end
    return v;
  endfunction

  // forced leaf types or a plain random mask
  function automatic logic [7:0] pick_half_mask();
    logic [7:0] m;
    m = 8'($urandom);
    case ($urandom_range(0, 4))
      0       : m = 8'hff;
      1       : m = 8'h00;
      2       : m[7:4] = 4'hf;
      3       : m[3:0] = 4'hf;
      default : ;
    endcase
    return m;
  endfunction

  task automatic send_frame();
    int                      llr[`POLAR_N];
    logic [`POLAR_LLR_W-1:0] v;
    logic [`POLAR_N-1:0]     frz;
    // only one frame may be in flight at a time
    @(negedge iclk);
    while (obusy) @(negedge iclk);
    for (int k = 0; k < `POLAR_N; k++) begin
      v = pick_llr();
      llr[k] = int'($signed(v));
      ialpha[k*`POLAR_LLR_W +: `POLAR_LLR_W] = v;
    end
    frz   = {pick_half_mask(), pick_half_mask()};
    ifrzb = frz;
    exp_q.push_back(frame_sc(llr, frz));
    ialpha_val = 1'b1;
    // strobe only counts on an enabled edge
    do @(posedge iclk); while (!iclkena);
    @(negedge iclk);
    ialpha_val = 1'b0;
  endtask

  // random clock enable stretches during the last frames
  initial begin
    int hold_cnt;
    iclkena  = 1'b1;
    hold_cnt = 0;
    forever begin
      @(negedge iclk);
      if (!stall_on) begin
        iclkena = 1'b1;
      end else if (hold_cnt > 0) begin
        hold_cnt--;
      end else begin
        iclkena  = ($urandom_range(0, 2) != 0);
        hold_cnt = $urandom_range(0, 3);
      end
    end
  end

  //--------------------------------------------------------------------------
  // monitor
  //--------------------------------------------------------------------------

  always @(negedge iclk) begin
    s_val  = obeta_val;
    s_busy = obusy;
    s_beta = obeta;
  end

  // acts on enabled edges only so that a held done state counts once
  always @(posedge iclk) begin
    logic [`POLAR_N-1:0] want;
    if (!ireset && iclkena) begin
      if (s_val) begin
        assert (in_flight) else begin
          errors++;
          $display("obeta_val raised with no frame in flight at %0t", $time);
        end
        if (in_flight) begin
          want = exp_q.pop_front();
          assert (s_beta === want) else begin
            errors++;
            $display("ERROR obeta expected %h got %h (frame %0d)", want, s_beta, frames_done);
          end
          frames_done++;
        end
        in_flight = 1'b0;
      end else begin
        // busy from the cycle after the strobe until obeta_val
        assert (s_busy === in_flight) else begin
          errors++;
          $display("ERROR obusy expected %h got %h at %0t", in_flight, s_busy, $time);
        end
      end
      if (ialpha_val) in_flight = 1'b1;
    end
  end

  //--------------------------------------------------------------------------
  // main sequence and watchdog
  //--------------------------------------------------------------------------

  initial begin
    void'($urandom(4));
    iclk        = 1'b0;
    ireset      = 1'b1;
    ialpha_val  = 1'b0;
    ialpha      = '0;
    ifrzb       = '0;
    errors      = 0;
    frames_done = 0;
    in_flight   = 1'b0;
    stall_on    = 1'b0;
    repeat (10) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
    // outputs must stay low in the quiet period
    repeat (8) @(negedge iclk);
    for (int n = 0; n < NUM_FRAMES; n++) begin
      stall_on = (n >= NUM_FRAMES - STALL_FRAMES);
      send_frame();
    end
    // clock enable back on while the last frame drains
    stall_on = 1'b0;
    while (obusy) @(negedge iclk);
    repeat (4) @(negedge iclk);
    assert (frames_done == NUM_FRAMES) else begin
      errors++;
      $display("only %0d of %0d frames produced a result", frames_done, NUM_FRAMES);
    end
    $display("errors: %0d, frames decoded: %0d of %0d", errors, frames_done, NUM_FRAMES);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("run timed out after %0d ns, errors: %0d, frames decoded: %0d of %0d",
             TIMEOUT_NS, errors, frames_done, NUM_FRAMES);
    $display("sim failed");
    $finish;
  end

endmodule

//--- list.f
+incdir+include
design/polar_pkg.sv
design/polar_frame_in.sv
design/polar_leaf_dec8.sv
design/polar_root_node16.sv
design/polar_dec16_top.sv
sim/tb_polar_dec16.sv

//--- Makefile
# Verilator build and run of the 16-bit polar decoder testbench

TOP = tb_polar_dec16

.PHONY: compile run clean

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): list.f include/*.svh design/*.sv sim/*.sv
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

# the log decides, a fail line or a missing pass line fails the target
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
